//--- divsqrt_pkg.sv
// ----------------------------------------------------------
// Shared widths, stage counts and payload types for the
// divide / square-root unit. Every design file imports it
// ----------------------------------------------------------

package divsqrt_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  // Operand and result width
  localparam int unsigned OPERAND_W = 16;
  // Tag that travels with each operation
  localparam int unsigned TAG_W = 4;
  // Square root of an OPERAND_W radicand has half the bits
  localparam int unsigned ROOT_W = OPERAND_W / 2;
  // Iteration counter, wide enough for OPERAND_W-1
  localparam int unsigned ITER_CNT_W = $clog2(OPERAND_W);

  // ----------------------------------------------------------
  // Pipeline depth
  // ----------------------------------------------------------
  // Register stages in front of the controller
  localparam int unsigned NUM_INP_REGS = 1;
  // Register stages behind the controller
  localparam int unsigned NUM_OUT_REGS = 1;

  // Operation select
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // Request payload, 37 bits
  typedef struct packed {
    logic [OPERAND_W-1:0] operand_a;
    logic [OPERAND_W-1:0] operand_b;
    op_e                  op;
    logic [TAG_W-1:0]     tag;
  } req_t;

  // Response payload, 21 bits
  typedef struct packed {
    logic [OPERAND_W-1:0] result;
    logic                 div_zero;
    logic [TAG_W-1:0]     tag;
  } rsp_t;

endpackage

//--- pipe_stage.sv
// ----------------------------------------------------------
// Chain of valid/ready register stages with synchronous
// flush. Payload type and depth are set by parameters, so the
// same block serves the request and the response side
// ----------------------------------------------------------

`timescale 1ns/100ps

module pipe_stage #(
  parameter type         payload_t = logic,
  parameter int unsigned NumRegs   = 1
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  // Downstream side
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  // Any stage occupied
  output logic     valid_any_o
);

  // Index i holds the item after i register stages
  payload_t              data_c [0:NumRegs];
  logic     [0:NumRegs]  valid_c;
  // Ready is combinational through all stages
  logic     [0:NumRegs]  ready_c;

  // Chain head comes straight from the upstream port
  assign data_c[0]  = in_data_i;
  assign valid_c[0] = in_valid_i;
  assign in_ready_o = ready_c[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    payload_t data_q;
    logic     valid_q;
    logic     load_en;

    // Advance when the next stage takes our item or only holds a bubble
    assign ready_c[i] = ready_c[i+1] | ~valid_c[i+1];

    // Valid bit follows the previous stage whenever we may advance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q <= 1'b0;
      end else if (flush_i) begin
        valid_q <= 1'b0;
      end else if (ready_c[i]) begin
        valid_q <= valid_c[i];
      end
    end

    // Load data only for a real item
    assign load_en = ready_c[i] & valid_c[i];

    always_ff @(posedge clk_i) begin
      if (load_en) begin
        data_q <= data_c[i];
      end
    end

    assign data_c[i+1]  = data_q;
    assign valid_c[i+1] = valid_q;
  end

  // Tail of the chain sees the downstream ready
  assign ready_c[NumRegs] = out_ready_i;
  assign out_data_o       = data_c[NumRegs];
  assign out_valid_o      = valid_c[NumRegs];

  // Occupancy over the registered stages only
  always_comb begin
    valid_any_o = 1'b0;
    for (int i = 1; i <= NumRegs; i++) begin
      valid_any_o = valid_any_o | valid_c[i];
    end
  end

endmodule

//--- divsqrt_iter.sv
// ----------------------------------------------------------
// Bit-serial unsigned core. Restoring division gives one
// quotient bit per cycle and digit-by-digit square root one
// root bit per cycle. Pulses done_o once and holds the result
// ----------------------------------------------------------

`timescale 1ns/100ps

module divsqrt_iter (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             kill_i,
  // Launch
  input  logic                             start_i,
  input  logic [divsqrt_pkg::OPERAND_W-1:0] operand_a_i,
  input  logic [divsqrt_pkg::OPERAND_W-1:0] operand_b_i,
  input  divsqrt_pkg::op_e                 op_i,
  // Completion
  output logic [divsqrt_pkg::OPERAND_W-1:0] result_o,
  output logic                             div_zero_o,
  output logic                             done_o
);

  import divsqrt_pkg::*;

  // Iteration state
  logic [OPERAND_W-1:0]  rem_q,  rem_d,  rem_src;
  logic [OPERAND_W-1:0]  quo_q,  quo_d,  quo_src;
  logic [ROOT_W-1:0]     root_q, root_d, root_src;
  logic [OPERAND_W-1:0]  dvs_q,  dvs_src;
  op_e                   op_q,   op_src;
  logic                  dz_q;
  // Control
  logic                  busy_q, done_q;
  logic [ITER_CNT_W-1:0] cnt_q;
  logic                  step_en;
  // Per-step scratch
  logic [OPERAND_W:0]    div_shift;
  logic [ROOT_W+2:0]     sqrt_shift;
  logic [ROOT_W+1:0]     sqrt_trial;

  // ----------------------------------------------------------
  // One iteration step
  // ----------------------------------------------------------
  // First step runs in the start cycle straight from the ports
  always_comb begin : iter_step
    rem_src  = start_i ? '0 : rem_q;
    quo_src  = start_i ? operand_a_i : quo_q;
    root_src = start_i ? '0 : root_q;
    dvs_src  = start_i ? operand_b_i : dvs_q;
    op_src   = start_i ? op_i : op_q;

    div_shift  = {rem_src[OPERAND_W-1:0], quo_src[OPERAND_W-1]};
    // Bring down the next two radicand bits
    sqrt_shift = {rem_src[ROOT_W:0], quo_src[OPERAND_W-1 -: 2]};
    // Trial value is 4*root + 1
    sqrt_trial = {root_src, 2'b01};

    rem_d  = rem_src;
    quo_d  = quo_src;
    root_d = root_src;

    if (op_src == OP_DIV) begin
      // Restoring step subtracts only if the divisor fits
      if (div_shift >= {1'b0, dvs_src}) begin
        rem_d = OPERAND_W'(div_shift - {1'b0, dvs_src});
        quo_d = {quo_src[OPERAND_W-2:0], 1'b1};
      end else begin
        rem_d = div_shift[OPERAND_W-1:0];
        quo_d = {quo_src[OPERAND_W-2:0], 1'b0};
      end
    end else begin
      rem_d = '0;
      // Radicand bits shift out two at a time
      quo_d = {quo_src[OPERAND_W-3:0], 2'b00};
      if (sqrt_shift >= {1'b0, sqrt_trial}) begin
        rem_d[ROOT_W+2:0] = sqrt_shift - {1'b0, sqrt_trial};
        root_d = {root_src[ROOT_W-2:0], 1'b1};
      end else begin
        rem_d[ROOT_W+2:0] = sqrt_shift;
        root_d = {root_src[ROOT_W-2:0], 1'b0};
      end
    end
  end

  assign step_en = start_i | busy_q;

  always_ff @(posedge clk_i) begin
    if (step_en) begin
      rem_q  <= rem_d;
      quo_q  <= quo_d;
      root_q <= root_d;
    end
    // Operands and flags are captured once per operation
    if (start_i) begin
      dvs_q <= operand_b_i;
      op_q  <= op_i;
      dz_q  <= (op_i == OP_DIV) && (operand_b_i == '0);
    end
  end

  // ----------------------------------------------------------
  // Iteration counter
  // ----------------------------------------------------------
  // Loaded with the steps left after the start cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (kill_i) begin
      // Abandon the operation without a done pulse
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= (op_i == OP_DIV) ? ITER_CNT_W'(OPERAND_W - 1) : ITER_CNT_W'(ROOT_W - 1);
      end else if (busy_q) begin
        cnt_q <= cnt_q - ITER_CNT_W'(1);
        // Done shows in the cycle after the last step
        if (cnt_q == ITER_CNT_W'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Division by zero forces all ones
  assign result_o   = dz_q ? '1 :
                      (op_q == OP_DIV) ? quo_q : {{(OPERAND_W - ROOT_W){1'b0}}, root_q};
  assign div_zero_o = dz_q;
  assign done_o     = done_q;

endmodule

//--- divsqrt_ctrl.sv
// ----------------------------------------------------------
// Idle/busy/hold controller. Starts one core operation at a
// time, keeps the tag of the running item and holds the
// response valid until the output side takes it
// ----------------------------------------------------------

`timescale 1ns/100ps

module divsqrt_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             flush_i,
  // Request from the input stage
  input  divsqrt_pkg::req_t                req_i,
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  // Core launch
  output logic                             start_o,
  output logic [divsqrt_pkg::OPERAND_W-1:0] operand_a_o,
  output logic [divsqrt_pkg::OPERAND_W-1:0] operand_b_o,
  output divsqrt_pkg::op_e                 op_o,
  // Core completion
  input  logic [divsqrt_pkg::OPERAND_W-1:0] result_i,
  input  logic                             div_zero_i,
  input  logic                             done_i,
  // Response to the output stage
  output divsqrt_pkg::rsp_t                rsp_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output logic                             busy_o
);

  import divsqrt_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_HOLD
  } state_e;

  state_e           state_q, state_d;
  logic [TAG_W-1:0] tag_q;

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_comb begin : ctrl_fsm
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      ST_IDLE: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_d = ST_BUSY;
        end
      end
      ST_BUSY: begin
        busy_o = 1'b1;
        // Core result is offered in the done cycle
        if (done_i) begin
          rsp_valid_o = 1'b1;
          if (rsp_ready_i) begin
            // Taken right away, next item may start
            req_ready_o = 1'b1;
            state_d     = req_valid_i ? ST_BUSY : ST_IDLE;
          end else begin
            state_d = ST_HOLD;
          end
        end
      end
      ST_HOLD: begin
        // Core keeps its result until the next start
        busy_o      = 1'b1;
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          req_ready_o = 1'b1;
          state_d     = req_valid_i ? ST_BUSY : ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase

    // Flush drops the item in flight
    if (flush_i) begin
      rsp_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Launch on an accepted request
  assign start_o     = req_valid_i & req_ready_o & ~flush_i;
  assign operand_a_o = req_i.operand_a;
  assign operand_b_o = req_i.operand_b;
  assign op_o        = req_i.op;

  // Tag of the running operation
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q <= req_i.tag;
    end
  end

  assign rsp_o.result   = result_i;
  assign rsp_o.div_zero = div_zero_i;
  assign rsp_o.tag      = tag_q;

endmodule

//--- divsqrt_top.sv
// ----------------------------------------------------------
// Divide / square-root unit top level. Input stage, controller,
// bit-serial core and output stage behind valid/ready ports
// ----------------------------------------------------------

`timescale 1ns/100ps

module divsqrt_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  // Request port
  input  divsqrt_pkg::req_t req_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  // Response port
  output divsqrt_pkg::rsp_t rsp_o,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  // Any item in flight
  output logic              busy_o
);

  import divsqrt_pkg::*;

  // Input stage to controller
  req_t                 req_q;
  logic                 req_valid;
  logic                 req_ready;
  // Controller to core
  logic                 core_start;
  logic [OPERAND_W-1:0] core_operand_a;
  logic [OPERAND_W-1:0] core_operand_b;
  op_e                  core_op;
  logic [OPERAND_W-1:0] core_result;
  logic                 core_div_zero;
  logic                 core_done;
  // Controller to output stage
  rsp_t                 rsp;
  logic                 rsp_valid;
  logic                 rsp_ready;
  // Occupancy
  logic                 inp_busy, ctrl_busy, out_busy;

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  pipe_stage #(
    .payload_t (req_t),
    .NumRegs   (NUM_INP_REGS)
  ) i_inp_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_data_i   (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_data_o  (req_q),
    .out_valid_o (req_valid),
    .out_ready_i (req_ready),
    .valid_any_o (inp_busy)
  );

  // ----------------------------------------------------------
  // Processing
  // ----------------------------------------------------------
  divsqrt_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .req_i       (req_q),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .start_o     (core_start),
    .operand_a_o (core_operand_a),
    .operand_b_o (core_operand_b),
    .op_o        (core_op),
    .result_i    (core_result),
    .div_zero_i  (core_div_zero),
    .done_i      (core_done),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .busy_o      (ctrl_busy)
  );

  // Flush also kills the running operation
  divsqrt_iter i_iter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .kill_i      (flush_i),
    .start_i     (core_start),
    .operand_a_i (core_operand_a),
    .operand_b_i (core_operand_b),
    .op_i        (core_op),
    .result_o    (core_result),
    .div_zero_o  (core_div_zero),
    .done_o      (core_done)
  );

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  pipe_stage #(
    .payload_t (rsp_t),
    .NumRegs   (NUM_OUT_REGS)
  ) i_out_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_data_i   (rsp),
    .in_valid_i  (rsp_valid),
    .in_ready_o  (rsp_ready),
    .out_data_o  (rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .valid_any_o (out_busy)
  );

  assign busy_o = inp_busy | ctrl_busy | out_busy;

endmodule

//--- tb_divsqrt_top.sv
// ----------------------------------------------------------
// Testbench for the divide / square-root unit. LFSR driven
// requests and back-pressure, a reference model with an
// in-order scoreboard, periodic flushes and a watchdog
// ----------------------------------------------------------

`timescale 1ns/100ps

module tb_divsqrt_top;

  import divsqrt_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_REQ     = 400;
  localparam int FLUSH_EVERY = 90;
  // Worst single item latency plus slack for back-pressure
  localparam int MAX_LAT     = OPERAND_W + NUM_INP_REGS + NUM_OUT_REGS + 4;
  localparam int WATCHDOG_NS = NUM_REQ * MAX_LAT * CLK_PERIOD * 4;

  logic        clk_i;
  logic        rst_n_i;
  logic        flush_i;
  req_t        req;
  logic        in_valid_i;
  logic        in_ready_o;
  rsp_t        rsp_o;
  logic        out_valid_o;
  logic        out_ready_i;
  logic        busy_o;

  // Stimulus source and scoreboard state
  logic [15:0] lfsr_q;
  rsp_t        exp_q[$];
  int          err_cnt, n_rsp, n_flush, n_div, n_sqrt, n_dz;
  logic        flush_done;

  divsqrt_top DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .req_i       (req),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .rsp_o       (rsp_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Random source
  // ----------------------------------------------------------
  // 16-bit Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Zero divisor forced about one time in eight
  function automatic req_t rand_req();
    req_t r;
    r.op        = (take_bits(1) != 0) ? OP_SQRT : OP_DIV;
    r.operand_a = OPERAND_W'(take_bits(OPERAND_W));
    r.operand_b = (take_bits(3) == 0) ? '0 : OPERAND_W'(take_bits(OPERAND_W));
    r.tag       = TAG_W'(take_bits(TAG_W));
    return r;
  endfunction

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic rsp_t model_rsp(input req_t r);
    rsp_t        e;
    int unsigned root;
    e.tag      = r.tag;
    e.div_zero = 1'b0;
    if (r.op == OP_DIV) begin
      if (r.operand_b == '0) begin
        e.result   = '1;
        e.div_zero = 1'b1;
      end else begin
        e.result = r.operand_a / r.operand_b;
      end
    end else begin
      // Largest root whose square still fits
      root = 0;
      while ((root + 1) * (root + 1) <= 32'(r.operand_a)) root++;
      e.result = OPERAND_W'(root);
    end
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      $display("ERROR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_idle_outputs();
    check_field("out_valid_o", 32'd0, 32'(out_valid_o));
    check_field("busy_o", 32'd0, 32'(busy_o));
    check_field("in_ready_o", 32'd1, 32'(in_ready_o));
  endtask

  // ----------------------------------------------------------
  // Scoreboard samples on the edge where transfers happen
  // ----------------------------------------------------------
  always @(posedge clk_i) begin : scoreboard
    rsp_t exp_rsp;
    if (rst_n_i) begin
      if (flush_done) begin
        check_field("busy_o", 32'd0, 32'(busy_o));
        check_field("out_valid_o", 32'd0, 32'(out_valid_o));
        flush_done = 1'b0;
      end
      // Busy while any accepted item has not left yet
      if (!flush_i) begin
        check_field("busy_o", 32'(exp_q.size() != 0), 32'(busy_o));
      end
      // Everything in flight is dropped
      if (flush_i) begin
        exp_q.delete();
        flush_done = 1'b1;
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(model_rsp(req));
      end
      if (out_valid_o && out_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("Response with tag %0h arrived with no request outstanding", rsp_o.tag);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          exp_rsp = exp_q.pop_front();
          check_field("rsp_o.result", 32'(exp_rsp.result), 32'(rsp_o.result));
          check_field("rsp_o.div_zero", 32'(exp_rsp.div_zero), 32'(rsp_o.div_zero));
          check_field("rsp_o.tag", 32'(exp_rsp.tag), 32'(rsp_o.tag));
          n_rsp++;
          if (exp_rsp.div_zero) n_dz++;
        end
      end
    end
  end

  // Count accepted operation kinds
  always @(posedge clk_i) begin
    if (rst_n_i && in_valid_i && in_ready_o) begin
      if (req.op == OP_DIV) n_div++;
      else n_sqrt++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, responses still outstanding", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin : stimulus
    int   n_acc;
    logic accepted;
    lfsr_q      = 16'd23726;
    err_cnt     = 0;
    n_rsp       = 0;
    n_flush     = 0;
    n_div       = 0;
    n_sqrt      = 0;
    n_dz        = 0;
    flush_done  = 1'b0;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    req         = '0;
    n_acc       = 0;

    @(negedge clk_i);
    check_idle_outputs();
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_idle_outputs();

    while (n_acc < NUM_REQ) begin
      @(posedge clk_i);
      accepted = in_valid_i && in_ready_o;
      if (accepted) n_acc++;
      flush_i <= 1'b0;
      if (accepted && (n_acc % FLUSH_EVERY == 0)) begin
        // Quiet flush cycle without a transfer on either side
        flush_i     <= 1'b1;
        in_valid_i  <= 1'b0;
        out_ready_i <= 1'b0;
        n_flush++;
      end else begin
        out_ready_i <= (take_bits(1) != 0);
        // Valid stays up until the item is taken
        if (accepted || !in_valid_i) begin
          if (take_bits(2) != 0 && n_acc < NUM_REQ) begin
            in_valid_i <= 1'b1;
            req        <= rand_req();
          end else begin
            in_valid_i <= 1'b0;
          end
        end
      end
    end

    // Drain with the output always ready
    @(posedge clk_i);
    flush_i     <= 1'b0;
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
    while (exp_q.size() != 0 || busy_o) @(posedge clk_i);
    repeat (2) @(posedge clk_i);

    assert (n_div != 0 && n_sqrt != 0 && n_dz != 0) else begin
      $display("Not every operation kind was exercised");
      err_cnt++;
    end
    $display("Done: %0d responses, %0d div, %0d sqrt, %0d div by zero, %0d flushes, %0d errors",
             n_rsp, n_div, n_sqrt, n_dz, n_flush, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- divsqrt.f
divsqrt_pkg.sv
pipe_stage.sv
divsqrt_iter.sv
divsqrt_ctrl.sv
divsqrt_top.sv
tb_divsqrt_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_divsqrt_top
RTL_TOP   := divsqrt_top
FILELIST  := divsqrt.f
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall --timing
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
